//--- cache_pkg.sv
package cache_pkg;

    // sizes
    localparam int WORD_W     = 16;
    localparam int LINE_WORDS = 16;   // also the column height
    localparam int IDX_W      = 4;
    localparam int CPU_ADDR_W = 16;
    localparam int TAG_W      = 12;   // upper part of the command address
    localparam int DDR_ADDR_W = 28;

    typedef logic [WORD_W-1:0] word_t;   // a row word or a column vector
    typedef logic [IDX_W-1:0]  idx_t;
    typedef logic [TAG_W-1:0]  tag_t;

    typedef enum logic [2:0] {
        ROW_LOAD  = 3'd1,
        ROW_STORE = 3'd2,
        COL_LOAD  = 3'd3,
        COL_STORE = 3'd4,
        FLUSH     = 3'd5
    } cache_op_t;

    typedef struct packed {
        cache_op_t             op;
        logic [CPU_ADDR_W-1:0] addr;   // tag above, word index in the low bits
        idx_t                  col;
        word_t                 wdata;  // column vector for COL_STORE
    } cache_cmd_t;

    typedef struct packed {
        word_t rdata;   // zero for stores and FLUSH
    } cache_resp_t;

    // first-word address of a block
    typedef struct packed {
        logic [DDR_ADDR_W-1:0] addr;
    } ddr_rd_req_t;

    typedef struct packed {
        word_t data;
    } ddr_fill_t;

    typedef struct packed {
        logic [DDR_ADDR_W-1:0] addr;
        word_t                 data;
        logic                  last;   // 16th beat of the burst
    } ddr_wr_t;

    // cpu side write into the storage
    typedef struct packed {
        logic  en;
        logic  is_col;
        idx_t  idx;    // word index for rows, bit position for columns
        word_t data;
    } matrix_wr_t;

endpackage

//--- tag_unit.sv
`timescale 1ns/100ps

module tag_unit (
    input  logic              clk,
    input  logic              rst,
    input  cache_pkg::tag_t   lookup_tag,
    input  logic              fill_done,
    input  cache_pkg::tag_t   fill_tag,
    input  logic              mark_dirty,
    input  logic              drain_done,
    output logic              hit,
    output logic              dirty,
    output cache_pkg::tag_t   victim_tag
);

    cache_pkg::tag_t tag_q;
    logic            valid_q;
    logic            dirty_q;

    // block tag and valid change only when a refill completes
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            tag_q   <= '0;
            valid_q <= 1'b0;
        end else if (fill_done) begin
            tag_q   <= fill_tag;
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            dirty_q <= 1'b0;
        end else if (fill_done || drain_done) begin
            dirty_q <= 1'b0;   // fresh block or written back
        end else if (mark_dirty) begin
            dirty_q <= 1'b1;
        end
    end

    assign hit        = valid_q && (tag_q == lookup_tag);
    assign dirty      = dirty_q;
    assign victim_tag = tag_q;   // address of the write-back

endmodule

//--- cache_matrix.sv
`timescale 1ns/100ps

module cache_matrix (
    input  logic                  clk,
    input  logic                  rst,
    input  cache_pkg::idx_t       row_idx,
    input  cache_pkg::idx_t       col_idx,
    input  cache_pkg::matrix_wr_t wr,
    input  logic                  fill_we,
    input  cache_pkg::idx_t       fill_idx,
    input  cache_pkg::word_t      fill_word,
    input  cache_pkg::idx_t       drain_idx,
    output cache_pkg::word_t      row_rdata,
    output cache_pkg::word_t      col_rdata,
    output cache_pkg::word_t      drain_word
);

    cache_pkg::word_t mem [cache_pkg::LINE_WORDS];

    // refill beats and cpu writes never overlap, fill takes priority anyway
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < cache_pkg::LINE_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (fill_we) begin
            mem[fill_idx] <= fill_word;
        end else if (wr.en) begin
            if (wr.is_col) begin
                // bit idx of word i takes bit i of the vector
                for (int i = 0; i < cache_pkg::LINE_WORDS; i++) begin
                    mem[i][wr.idx] <= wr.data[i];
                end
            end else begin
                mem[wr.idx] <= wr.data;
            end
        end
    end

    assign row_rdata  = mem[row_idx];
    assign drain_word = mem[drain_idx];

    // column gather, word i lands in bit i
    always_comb begin
        col_rdata = '0;
        for (int i = 0; i < cache_pkg::LINE_WORDS; i++) begin
            col_rdata[i] = mem[i][col_idx];
        end
    end

endmodule

//--- ddr_port.sv
`timescale 1ns/100ps

module ddr_port (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start_fill,
    input  logic                   start_drain,
    input  cache_pkg::tag_t        tag,
    output logic                   done,
    output cache_pkg::ddr_rd_req_t rd_req,
    output logic                   rd_req_valid,
    input  logic                   rd_req_ready,
    input  cache_pkg::ddr_fill_t   fill,
    input  logic                   fill_valid,
    output logic                   fill_ready,
    output cache_pkg::ddr_wr_t     wr,
    output logic                   wr_valid,
    input  logic                   wr_ready,
    output logic                   fill_we,
    output cache_pkg::idx_t        fill_idx,
    output cache_pkg::word_t       fill_word,
    output cache_pkg::idx_t        drain_idx,
    input  cache_pkg::word_t       drain_word
);

    typedef enum logic [1:0] {
        P_IDLE,
        P_DRAIN,
        P_REQ,
        P_FILL
    } port_state_t;

    port_state_t     state;
    cache_pkg::tag_t tag_q;
    cache_pkg::idx_t cnt;   // beat counter, shared by both directions
    logic            last_beat;
    logic            wr_xfer;
    logic            fill_xfer;

    assign last_beat = (cnt == cache_pkg::idx_t'(cache_pkg::LINE_WORDS - 1));
    assign wr_xfer   = wr_valid && wr_ready;
    assign fill_xfer = fill_valid && fill_ready;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= P_IDLE;
            tag_q <= '0;
            cnt   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                P_IDLE: begin
                    cnt   <= '0;
                    tag_q <= tag;
                    if (start_drain) begin
                        state <= P_DRAIN;
                    end else if (start_fill) begin
                        state <= P_REQ;
                    end
                end
                P_DRAIN: if (wr_xfer) begin
                    cnt <= cnt + 1'b1;
                    if (last_beat) begin
                        state <= P_IDLE;
                        done  <= 1'b1;
                    end
                end
                P_REQ: if (rd_req_ready) state <= P_FILL;
                P_FILL: if (fill_xfer) begin
                    cnt <= cnt + 1'b1;
                    if (last_beat) begin
                        state <= P_IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= P_IDLE;
            endcase
        end
    end

    // word i of block t sits at {t, i}
    always_comb begin
        rd_req.addr  = cache_pkg::DDR_ADDR_W'({tag_q, {cache_pkg::IDX_W{1'b0}}});
        rd_req_valid = (state == P_REQ);
        wr.addr      = cache_pkg::DDR_ADDR_W'({tag_q, cnt});
        wr.data      = drain_word;
        wr.last      = last_beat;
        wr_valid     = (state == P_DRAIN);
        fill_ready   = (state == P_FILL);
        fill_we      = fill_xfer;
        fill_idx     = cnt;
        fill_word    = fill.data;
        drain_idx    = cnt;
    end

endmodule

//--- cache_ctrl.sv
`timescale 1ns/100ps

module cache_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  cache_pkg::cache_cmd_t  cmd,
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    output cache_pkg::cache_resp_t resp,
    output logic                   resp_valid,
    input  logic                   resp_ready,
    input  logic                   hit,
    input  logic                   dirty,
    input  cache_pkg::tag_t        victim_tag,
    output cache_pkg::tag_t        lookup_tag,
    output logic                   fill_done,
    output cache_pkg::tag_t        fill_tag,
    output logic                   mark_dirty,
    output cache_pkg::idx_t        row_idx,
    output cache_pkg::idx_t        col_idx,
    output cache_pkg::matrix_wr_t  wr,
    input  cache_pkg::word_t       row_rdata,
    input  cache_pkg::word_t       col_rdata,
    output logic                   start_fill,
    output logic                   start_drain,
    output cache_pkg::tag_t        port_tag,
    input  logic                   port_done,
    output logic                   drain_done
);

    typedef enum logic [2:0] {
        C_INIT,
        C_IDLE,
        C_LOOKUP,
        C_MISS_DRAIN,
        C_MISS_FILL,
        C_FLUSH_DRAIN
    } ctrl_state_t;

    ctrl_state_t           state;
    cache_pkg::cache_cmd_t cmd_q;
    logic                  in_lookup;
    logic                  is_store;
    logic                  is_flush;
    logic                  resp_load;
    cache_pkg::word_t      resp_data;

    assign cmd_ready  = (state == C_IDLE) && !resp_valid;
    assign in_lookup  = (state == C_LOOKUP);
    assign is_store   = (cmd_q.op == cache_pkg::ROW_STORE) || (cmd_q.op == cache_pkg::COL_STORE);
    assign is_flush   = (cmd_q.op == cache_pkg::FLUSH);
    assign lookup_tag = cmd_q.addr[cache_pkg::CPU_ADDR_W-1 -: cache_pkg::TAG_W];
    assign row_idx    = cmd_q.addr[cache_pkg::IDX_W-1:0];
    assign col_idx    = cmd_q.col;

    // store hits write the matrix during the lookup cycle
    always_comb begin
        wr.en     = in_lookup && hit && is_store;
        wr.is_col = (cmd_q.op == cache_pkg::COL_STORE);
        wr.idx    = wr.is_col ? cmd_q.col : row_idx;
        wr.data   = cmd_q.wdata;
    end
    assign mark_dirty = wr.en;

    // a miss drains a dirty victim first, flush drains only when dirty
    assign start_drain = in_lookup && dirty && (is_flush || !hit);
    assign start_fill  = (in_lookup && !is_flush && !hit && !dirty)
                       || ((state == C_MISS_DRAIN) && port_done);
    assign port_tag    = start_drain ? victim_tag : lookup_tag;
    assign drain_done  = port_done && ((state == C_MISS_DRAIN) || (state == C_FLUSH_DRAIN));
    assign fill_done   = port_done && (state == C_MISS_FILL);
    assign fill_tag    = lookup_tag;

    assign resp_load = (in_lookup && (is_flush ? !dirty : hit))
                     || ((state == C_FLUSH_DRAIN) && port_done);

    always_comb begin
        case (cmd_q.op)
            cache_pkg::ROW_LOAD: resp_data = row_rdata;
            cache_pkg::COL_LOAD: resp_data = col_rdata;
            default:             resp_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= C_INIT;
            resp_valid <= 1'b0;
        end else begin
            if (resp_valid && resp_ready) resp_valid <= 1'b0;
            if (resp_load) resp_valid <= 1'b1;
            case (state)
                C_INIT: state <= C_IDLE;
                C_IDLE: if (cmd_valid && cmd_ready) state <= C_LOOKUP;
                C_LOOKUP: begin
                    if (resp_load) begin
                        state <= C_IDLE;
                    end else if (is_flush) begin
                        state <= C_FLUSH_DRAIN;
                    end else begin
                        state <= dirty ? C_MISS_DRAIN : C_MISS_FILL;
                    end
                end
                C_MISS_DRAIN:  if (port_done) state <= C_MISS_FILL;
                C_MISS_FILL:   if (port_done) state <= C_LOOKUP;   // retry now hits
                C_FLUSH_DRAIN: if (port_done) state <= C_IDLE;
                default:       state <= C_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) cmd_q <= cmd;
        if (resp_load) resp.rdata <= resp_data;
    end

endmodule

//--- data_cache.sv
`timescale 1ns/100ps

module data_cache (
    input  logic                   clk,
    input  logic                   rst,
    input  cache_pkg::cache_cmd_t  cmd,
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    output cache_pkg::cache_resp_t resp,
    output logic                   resp_valid,
    input  logic                   resp_ready,
    output cache_pkg::ddr_rd_req_t rd_req,
    output logic                   rd_req_valid,
    input  logic                   rd_req_ready,
    input  cache_pkg::ddr_fill_t   fill,
    input  logic                   fill_valid,
    output logic                   fill_ready,
    output cache_pkg::ddr_wr_t     wr,
    output logic                   wr_valid,
    input  logic                   wr_ready
);

    cache_pkg::tag_t       lookup_tag;
    cache_pkg::tag_t       fill_tag;
    cache_pkg::tag_t       victim_tag;
    cache_pkg::tag_t       port_tag;
    logic                  hit;
    logic                  dirty;
    logic                  fill_done;
    logic                  drain_done;
    logic                  mark_dirty;
    logic                  start_fill;
    logic                  start_drain;
    logic                  port_done;
    cache_pkg::idx_t       row_idx;
    cache_pkg::idx_t       col_idx;
    cache_pkg::matrix_wr_t mtx_wr;
    cache_pkg::word_t      row_rdata;
    cache_pkg::word_t      col_rdata;
    logic                  fill_we;
    cache_pkg::idx_t       fill_idx;
    cache_pkg::word_t      fill_word;
    cache_pkg::idx_t       drain_idx;
    cache_pkg::word_t      drain_word;

    tag_unit tag_unit_i (
        .clk(clk), .rst(rst), .lookup_tag(lookup_tag), .fill_done(fill_done),
        .fill_tag(fill_tag), .mark_dirty(mark_dirty), .drain_done(drain_done),
        .hit(hit), .dirty(dirty), .victim_tag(victim_tag)
    );

    cache_matrix cache_matrix_i (
        .clk(clk), .rst(rst), .row_idx(row_idx), .col_idx(col_idx), .wr(mtx_wr),
        .fill_we(fill_we), .fill_idx(fill_idx), .fill_word(fill_word),
        .drain_idx(drain_idx), .row_rdata(row_rdata), .col_rdata(col_rdata),
        .drain_word(drain_word)
    );

    ddr_port ddr_port_i (
        .clk(clk), .rst(rst), .start_fill(start_fill), .start_drain(start_drain),
        .tag(port_tag), .done(port_done),
        .rd_req(rd_req), .rd_req_valid(rd_req_valid), .rd_req_ready(rd_req_ready),
        .fill(fill), .fill_valid(fill_valid), .fill_ready(fill_ready),
        .wr(wr), .wr_valid(wr_valid), .wr_ready(wr_ready),
        .fill_we(fill_we), .fill_idx(fill_idx), .fill_word(fill_word),
        .drain_idx(drain_idx), .drain_word(drain_word)
    );

    cache_ctrl cache_ctrl_i (
        .clk(clk), .rst(rst), .cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .resp(resp), .resp_valid(resp_valid), .resp_ready(resp_ready),
        .hit(hit), .dirty(dirty), .victim_tag(victim_tag), .lookup_tag(lookup_tag),
        .fill_done(fill_done), .fill_tag(fill_tag), .mark_dirty(mark_dirty),
        .row_idx(row_idx), .col_idx(col_idx), .wr(mtx_wr),
        .row_rdata(row_rdata), .col_rdata(col_rdata),
        .start_fill(start_fill), .start_drain(start_drain), .port_tag(port_tag),
        .port_done(port_done), .drain_done(drain_done)
    );

endmodule

//--- tb_ddr_model.sv
`timescale 1ns/100ps

module tb_ddr_model (
    input  logic                   clk,
    input  logic                   rst,
    input  cache_pkg::ddr_rd_req_t rd_req,
    input  logic                   rd_req_valid,
    output logic                   rd_req_ready,
    output cache_pkg::ddr_fill_t   fill,
    output logic                   fill_valid,
    input  logic                   fill_ready,
    input  cache_pkg::ddr_wr_t     wr,
    input  logic                   wr_valid,
    output logic                   wr_ready,
    output logic [31:0]            beat_count
);

    localparam int MEM_WORDS = 4096;

    cache_pkg::word_t mem [MEM_WORDS];
    logic [31:0]      lfsr_state;
    logic [11:0]      base;
    int               cnt;
    logic             busy;
    logic             req_x;
    logic             fill_x;

    // galois lfsr stepped once per bit taken
    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[14:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003)
                                       : (lfsr_state >> 1);
        end
        return bits;
    endfunction

    initial begin
        lfsr_state   = 32'd69195;
        rd_req_ready = 1'b0;
        fill_valid   = 1'b0;
        fill         = '0;
        wr_ready     = 1'b0;
        beat_count   = '0;
        busy         = 1'b0;
        cnt          = 0;
        base         = '0;
        req_x        = 1'b0;
        fill_x       = 1'b0;
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a] = take_bits(16);
        end
    end

    // handshakes are sampled mid cycle before their transfer edge
    always @(negedge clk) begin
        req_x  = rd_req_valid && rd_req_ready;
        fill_x = fill_valid && fill_ready;
        if (wr_valid && wr_ready) begin
            mem[wr.addr[11:0]] = wr.data;
            beat_count = beat_count + 1;
        end
    end

    always @(posedge clk) begin
        #2;
        if (!rst) begin
            busy     = 1'b0;
            cnt      = 0;
            wr_ready = 1'b0;
        end else begin
            if (req_x) begin
                base = rd_req.addr[11:0];
                busy = 1'b1;
                cnt  = 0;
            end else if (fill_x) begin
                cnt = cnt + 1;
                if (cnt == cache_pkg::LINE_WORDS) busy = 1'b0;
            end
            wr_ready = (take_bits(2) != 2'b00);   // stalls about a quarter of cycles
        end
        req_x        = 1'b0;
        fill_x       = 1'b0;
        rd_req_ready = rst && !busy;
        fill_valid   = busy;
        fill.data    = mem[base + 12'(cnt)];
    end

endmodule

//--- tb_data_cache.sv
`timescale 1ns/100ps

module tb_data_cache;

    localparam int NUM_TESTS = 15;

    typedef struct packed {
        cache_pkg::cache_cmd_t cmd;
        cache_pkg::word_t      exp;
        logic                  exp_hit;   // latency is checked on hits
        logic                  exp_rd;    // a refill request is expected
        logic [27:0]           rd_addr;
        logic [5:0]            beats;     // write-back beats expected
        cache_pkg::tag_t       wb_tag;
        logic                  stall;     // hold resp_ready low for a while
    } test_t;

    logic                   clk;
    logic                   rst;
    cache_pkg::cache_cmd_t  cmd;
    logic                   cmd_valid;
    logic                   cmd_ready;
    cache_pkg::cache_resp_t resp;
    logic                   resp_valid;
    logic                   resp_ready;
    cache_pkg::ddr_rd_req_t rd_req;
    logic                   rd_req_valid;
    logic                   rd_req_ready;
    cache_pkg::ddr_fill_t   fill;
    logic                   fill_valid;
    logic                   fill_ready;
    cache_pkg::ddr_wr_t     wr;
    logic                   wr_valid;
    logic                   wr_ready;
    logic [31:0]            beat_count;

    test_t            tests [NUM_TESTS];
    cache_pkg::word_t ref_mem [4096];
    cache_pkg::word_t ref_line [16];
    cache_pkg::tag_t  ref_tag;
    logic             ref_valid;
    logic             ref_dirty;
    logic [27:0]      rd_q [$];
    logic [27:0]      wb_addr_q [$];
    logic             wb_last_q [$];
    int               err_count;
    int               pass_tests;
    int               fail_tests;

    data_cache data_cache_i (
        .clk(clk), .rst(rst), .cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .resp(resp), .resp_valid(resp_valid), .resp_ready(resp_ready),
        .rd_req(rd_req), .rd_req_valid(rd_req_valid), .rd_req_ready(rd_req_ready),
        .fill(fill), .fill_valid(fill_valid), .fill_ready(fill_ready),
        .wr(wr), .wr_valid(wr_valid), .wr_ready(wr_ready)
    );

    tb_ddr_model ddr_model_i (
        .clk(clk), .rst(rst), .rd_req(rd_req), .rd_req_valid(rd_req_valid),
        .rd_req_ready(rd_req_ready), .fill(fill), .fill_valid(fill_valid),
        .fill_ready(fill_ready), .wr(wr), .wr_valid(wr_valid), .wr_ready(wr_ready),
        .beat_count(beat_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (NUM_TESTS * 200) @(posedge clk);
        $display("timeout: the DUT stopped answering");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // record DDR traffic seen by the model
    always @(negedge clk) begin
        if (rd_req_valid && rd_req_ready) rd_q.push_back(rd_req.addr);
        if (wr_valid && wr_ready) begin
            wb_addr_q.push_back(wr.addr);
            wb_last_q.push_back(wr.last);
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic set_row(input int n, input cache_pkg::cache_op_t op, input logic [15:0] addr,
                           input logic [3:0] col, input logic [15:0] wdata, input logic stall);
        tests[n]           = '0;
        tests[n].cmd.op    = op;
        tests[n].cmd.addr  = addr;
        tests[n].cmd.col   = col;
        tests[n].cmd.wdata = wdata;
        tests[n].stall     = stall;
    endtask

    task automatic write_back(input int n);
        for (int i = 0; i < 16; i++) begin
            ref_mem[{ref_tag, 4'(i)}] = ref_line[i];
        end
        tests[n].beats  = 6'd16;
        tests[n].wb_tag = ref_tag;
        ref_dirty       = 1'b0;
    endtask

    // one-block cache model over a copy of the DDR memory
    task automatic build_expected();
        cache_pkg::tag_t t;
        logic [3:0]      idx;
        logic [3:0]      col;
        for (int n = 0; n < NUM_TESTS; n++) begin
            t   = tests[n].cmd.addr[15:4];
            idx = tests[n].cmd.addr[3:0];
            col = tests[n].cmd.col;
            if (tests[n].cmd.op == cache_pkg::FLUSH) begin
                if (ref_valid && ref_dirty) write_back(n);
                continue;
            end
            tests[n].exp_hit = ref_valid && (ref_tag == t);
            if (!tests[n].exp_hit) begin
                if (ref_valid && ref_dirty) write_back(n);
                for (int i = 0; i < 16; i++) ref_line[i] = ref_mem[{t, 4'(i)}];
                ref_tag          = t;
                ref_valid        = 1'b1;
                tests[n].exp_rd  = 1'b1;
                tests[n].rd_addr = {12'd0, t, 4'd0};
            end
            case (tests[n].cmd.op)
                cache_pkg::ROW_LOAD: tests[n].exp = ref_line[idx];
                cache_pkg::COL_LOAD: for (int i = 0; i < 16; i++) begin
                    tests[n].exp[i] = ref_line[i][col];
                end
                cache_pkg::ROW_STORE: begin
                    ref_line[idx] = tests[n].cmd.wdata;
                    ref_dirty     = 1'b1;
                end
                default: begin
                    for (int i = 0; i < 16; i++) ref_line[i][col] = tests[n].cmd.wdata[i];
                    ref_dirty = 1'b1;
                end
            endcase
        end
    endtask

    task automatic run_test(input int n);
        int               lat;
        int               errs_before;
        logic [31:0]      beats_before;
        cache_pkg::word_t got;
        errs_before  = err_count;
        beats_before = beat_count;
        rd_q.delete();
        wb_addr_q.delete();
        wb_last_q.delete();
        @(posedge clk);
        #1;
        cmd        = tests[n].cmd;
        cmd_valid  = 1'b1;
        resp_ready = !tests[n].stall;
        do @(negedge clk); while (!cmd_ready);
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!resp_valid);
        got = resp.rdata;
        if (tests[n].stall) begin
            repeat (3) @(posedge clk);
            #1;
            if (!resp_valid) begin
                $display("response withdrawn while resp_ready was low, t=%0t", $time);
                err_count++;
            end
            check("resp.rdata held", 32'(resp.rdata), 32'(got));
            check("cmd_ready while resp waits", 32'(cmd_ready), 32'(0));
            resp_ready = 1'b1;
        end
        check("resp.rdata", 32'(got), 32'(tests[n].exp));
        if (tests[n].exp_hit) check("hit latency", lat, 2);
        check("rd_req count", rd_q.size(), 32'(tests[n].exp_rd));
        if (tests[n].exp_rd && rd_q.size() > 0) check("rd_req.addr", rd_q[0], tests[n].rd_addr);
        check("wr beats", wb_addr_q.size(), 32'(tests[n].beats));
        check("ddr beat count", beat_count - beats_before, 32'(tests[n].beats));
        for (int i = 0; i < wb_addr_q.size() && i < 16; i++) begin
            check("wr.addr", wb_addr_q[i], {12'd0, tests[n].wb_tag, 4'(i)});
            check("wr.last", 32'(wb_last_q[i]), 32'(i == 15));
        end
        if (err_count == errs_before) begin
            $display("test %0d op %0d addr %h: ok", n, tests[n].cmd.op, tests[n].cmd.addr);
            pass_tests++;
        end else begin
            $display("test %0d op %0d addr %h: failed", n, tests[n].cmd.op, tests[n].cmd.addr);
            fail_tests++;
        end
    endtask

    initial begin
        rst        = 1'b0;
        cmd        = '0;
        cmd_valid  = 1'b0;
        resp_ready = 1'b1;
        err_count  = 0;
        pass_tests = 0;
        fail_tests = 0;
        ref_tag    = '0;
        ref_valid  = 1'b0;
        ref_dirty  = 1'b0;
        for (int i = 0; i < 16; i++) ref_line[i] = '0;
        #1;
        for (int a = 0; a < 4096; a++) ref_mem[a] = ddr_model_i.mem[a];
        set_row(0,  cache_pkg::ROW_LOAD,  16'h0123, 4'd0, 16'h0000, 1'b0);   // clean miss
        set_row(1,  cache_pkg::ROW_STORE, 16'h0125, 4'd0, 16'hbeef, 1'b0);
        set_row(2,  cache_pkg::ROW_LOAD,  16'h0125, 4'd0, 16'h0000, 1'b0);
        set_row(3,  cache_pkg::COL_LOAD,  16'h0120, 4'd3, 16'h0000, 1'b0);
        set_row(4,  cache_pkg::COL_STORE, 16'h0120, 4'd7, 16'ha5c3, 1'b0);
        set_row(5,  cache_pkg::ROW_LOAD,  16'h0120, 4'd0, 16'h0000, 1'b0);
        set_row(6,  cache_pkg::ROW_LOAD,  16'h0125, 4'd0, 16'h0000, 1'b0);
        set_row(7,  cache_pkg::ROW_LOAD,  16'h012f, 4'd0, 16'h0000, 1'b0);
        set_row(8,  cache_pkg::COL_LOAD,  16'h0120, 4'd7, 16'h0000, 1'b0);
        set_row(9,  cache_pkg::ROW_LOAD,  16'h0344, 4'd0, 16'h0000, 1'b0);   // evicts dirty block
        set_row(10, cache_pkg::ROW_STORE, 16'h0349, 4'd0, 16'h1234, 1'b0);
        set_row(11, cache_pkg::FLUSH,     16'h0340, 4'd0, 16'h0000, 1'b1);
        set_row(12, cache_pkg::FLUSH,     16'h0340, 4'd0, 16'h0000, 1'b1);   // nothing left to write
        set_row(13, cache_pkg::ROW_LOAD,  16'h0012, 4'd0, 16'h0000, 1'b0);
        set_row(14, cache_pkg::ROW_LOAD,  16'h0349, 4'd0, 16'h0000, 1'b0);
        build_expected();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;
        // first cycle out of reset
        @(negedge clk);
        check("cmd_ready after reset", 32'(cmd_ready), 32'(0));
        check("resp_valid after reset", 32'(resp_valid), 32'(0));
        check("rd_req_valid after reset", 32'(rd_req_valid), 32'(0));
        check("wr_valid after reset", 32'(wr_valid), 32'(0));
        check("fill_ready after reset", 32'(fill_ready), 32'(0));
        if (err_count == 0) $display("reset values: ok");
        else $display("reset values: failed");
        for (int n = 0; n < NUM_TESTS; n++) run_test(n);
        repeat (2) @(posedge clk);
        for (int a = 0; a < 4096; a++) begin
            check($sformatf("ddr mem[%h]", a), 32'(ddr_model_i.mem[a]), 32'(ref_mem[a]));
        end
        $display("tests passed %0d failed %0d, errors %0d", pass_tests, fail_tests, err_count);
        if (fail_tests == 0 && err_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- src.f
cache_pkg.sv
tag_unit.sv
cache_matrix.sv
ddr_port.sv
cache_ctrl.sv
data_cache.sv
tb_ddr_model.sv
tb_data_cache.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
    --top-module tb_data_cache \
    -f src.f \
    -o sim_data_cache

./obj_dir/sim_data_cache | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi

echo "simulation finished"
exit 0
